// File: dv/soc_tb.sv
`default_nettype none

module soc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import axi_lite_pkg::*;
	import soc_map_pkg::*;

	localparam int NUM_MEM = 32;
	localparam int NUM_STRB = 8;
	localparam int NUM_BAD = 4;
	localparam int NUM_BP = 4;
	localparam int NUM_TXNS = 2*NUM_MEM + 2*NUM_STRB + 8 + 2*NUM_BAD + 5 + 2*NUM_BP + 1;
	localparam int TIMEOUT_CYCLES = NUM_TXNS * 40 + 1000;

	logic clk_i = 1'b0;
	logic rst_i;
	addr_t s_awaddr_i, s_araddr_i;
	data_t s_wdata_i, s_rdata_o;
	strb_t s_wstrb_i;
	resp_t s_bresp_o, s_rresp_o;
	logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
	logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	logic [SW_WIDTH-1:0] sw_i;
	logic [LED_WIDTH-1:0] led_o;

	// Reference model
	data_t ref_mem [MEM_WORDS];
	logic [LED_WIDTH-1:0] ref_led;
	logic [SW_WIDTH-1:0] ref_sw;

	int wr_idx [NUM_MEM];  // Word indices written by the first test
	addr_t bad_addr [NUM_BAD] = '{32'h0000_0400, 32'h1000_0014, 32'h0FFF_FFFC, 32'hFFFF_FFFC};
	integer seed = 32'h592fbcc5;
	int data_errors = 0;
	int resp_errors = 0;
	int other_errors = 0;
	data_t exp_data_q[$], act_data_q[$];
	resp_t exp_resp_q[$], act_resp_q[$];
	string data_name_q[$], resp_name_q[$];

	soc_top soc_top_i (.*);

	always #10 clk_i = ~clk_i;

	function automatic logic in_mem(input addr_t addr);
		return addr >= MEM_START_ADDRESS && addr <= MEM_END_ADDRESS;
	endfunction

	function automatic logic in_gpio(input addr_t addr);
		return addr >= GPIO_START_ADDRESS && addr <= GPIO_END_ADDRESS;
	endfunction

	function automatic resp_t ref_resp(input addr_t addr);
		return (in_mem(addr) || in_gpio(addr)) ? RESP_OKAY : RESP_DECERR;
	endfunction

	function automatic data_t ref_read(input addr_t addr);
		if (in_mem(addr))
			return ref_mem[addr[MEM_INDEX_WIDTH+1:2]];
		if (in_gpio(addr) && addr[3:0] == GPIO_SW_OFFSET)
			return data_t'(ref_sw);
		if (in_gpio(addr) && addr[3:0] == GPIO_LED_OFFSET)
			return data_t'(ref_led);
		return '0;  // Unused GPIO offsets and unmapped space
	endfunction

	function automatic void ref_write(input addr_t addr, input data_t data, input strb_t strb);
		for (int i = 0; i < STRB_WIDTH; i++) begin
			if (in_mem(addr) && strb[i])
				ref_mem[addr[MEM_INDEX_WIDTH+1:2]][8*i +: 8] = data[8*i +: 8];
		end
		if (in_gpio(addr) && addr[3:0] == GPIO_LED_OFFSET && strb[0])
			ref_led = data[LED_WIDTH-1:0];
	endfunction

	function automatic int rand_stall();
		return {$random(seed)} % 12 + 1;
	endfunction

	task automatic check_data(input data_t exp_val, input data_t act_val, input string name);
		if (act_val !== exp_val) begin
			data_errors++;
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
		end
	endtask

	task automatic check_resp(input resp_t exp_val, input resp_t act_val, input string name);
		if (act_val !== exp_val) begin
			resp_errors++;
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Failure at %0d ns: %s", $time, what);
	endtask

	// Queue a pair for the compare process
	task automatic expect_data(input data_t exp_val, input data_t act_val, input string name);
		exp_data_q.push_back(exp_val);
		act_data_q.push_back(act_val);
		data_name_q.push_back(name);
	endtask

	task automatic expect_resp(input resp_t exp_val, input resp_t act_val, input string name);
		exp_resp_q.push_back(exp_val);
		act_resp_q.push_back(act_val);
		resp_name_q.push_back(name);
	endtask

	always @(negedge clk_i) begin
		while (act_data_q.size() > 0)
			check_data(exp_data_q.pop_front(), act_data_q.pop_front(), data_name_q.pop_front());
		while (act_resp_q.size() > 0)
			check_resp(exp_resp_q.pop_front(), act_resp_q.pop_front(), resp_name_q.pop_front());
	end

	// Called and returning 2 ns after a rising edge
	task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
		input int stall, output resp_t resp);
		logic accepted;
		s_awaddr_i = addr;
		s_wdata_i = data;
		s_wstrb_i = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i = 1'b1;
		s_bready_i = (stall == 0);
		do begin
			@(negedge clk_i);
			accepted = s_awready_o && s_wready_o;
			@(posedge clk_i);
		end while (!accepted);
		#2;
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		@(negedge clk_i);
		if (!s_bvalid_o)
			report_failure("write response not valid one cycle after the request");
		while (!s_bvalid_o)
			@(negedge clk_i);
		resp = s_bresp_o;
		repeat (stall) begin
			@(negedge clk_i);
			if (!s_bvalid_o)
				report_failure("write response dropped while bready was low");
			expect_resp(resp, s_bresp_o, "s_bresp_o");
		end
		if (stall > 0) begin
			@(posedge clk_i);
			#2;
			s_bready_i = 1'b1;
		end
		@(posedge clk_i);
		#2;
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read(input addr_t addr, input int stall, output data_t data,
		output resp_t resp);
		logic accepted;
		s_araddr_i = addr;
		s_arvalid_i = 1'b1;
		s_rready_i = (stall == 0);
		do begin
			@(negedge clk_i);
			accepted = s_arready_o;
			@(posedge clk_i);
		end while (!accepted);
		#2;
		s_arvalid_i = 1'b0;
		@(negedge clk_i);
		if (!s_rvalid_o)
			report_failure("read data not valid one cycle after the request");
		while (!s_rvalid_o)
			@(negedge clk_i);
		data = s_rdata_o;
		resp = s_rresp_o;
		repeat (stall) begin
			@(negedge clk_i);
			if (!s_rvalid_o)
				report_failure("read data dropped while rready was low");
			expect_data(data, s_rdata_o, "s_rdata_o");
			expect_resp(resp, s_rresp_o, "s_rresp_o");
		end
		if (stall > 0) begin
			@(posedge clk_i);
			#2;
			s_rready_i = 1'b1;
		end
		@(posedge clk_i);
		#2;
		s_rready_i = 1'b0;
	endtask

	task automatic write_check(input addr_t addr, input data_t data, input strb_t strb,
		input int stall);
		resp_t exp_resp;
		resp_t act_resp;
		exp_resp = ref_resp(addr);
		axi_write(addr, data, strb, stall, act_resp);
		ref_write(addr, data, strb);
		expect_resp(exp_resp, act_resp, "s_bresp_o");
	endtask

	task automatic read_check(input addr_t addr, input int stall);
		data_t exp_data;
		data_t act_data;
		resp_t exp_resp;
		resp_t act_resp;
		exp_data = ref_read(addr);
		exp_resp = ref_resp(addr);
		axi_read(addr, stall, act_data, act_resp);
		expect_data(exp_data, act_data, "s_rdata_o");
		expect_resp(exp_resp, act_resp, "s_rresp_o");
	endtask

	task automatic reset_dut();
		rst_i = 1'b1;
		repeat (5) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		ref_led = '0;
		if (s_bvalid_o || s_rvalid_o)
			report_failure("response valid high right after reset");
		expect_data('0, data_t'(led_o), "led_o");
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_i);
		$display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		data_t data;
		int stall_w;
		int stall_r;
		s_awaddr_i = '0;
		s_araddr_i = '0;
		s_wdata_i = '0;
		s_wstrb_i = '0;
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		ref_sw = '0;
		sw_i = ref_sw;
		reset_dut();

		// One full word in each stretch of eight words
		for (int k = 0; k < NUM_MEM; k++) begin
			wr_idx[k] = k * (MEM_WORDS / NUM_MEM) + {$random(seed)} % (MEM_WORDS / NUM_MEM);
			write_check(addr_t'(wr_idx[k] * 4), $random(seed), '1, 0);
		end
		for (int k = 0; k < NUM_MEM; k++)
			read_check(addr_t'(wr_idx[k] * 4), 0);

		for (int k = 0; k < NUM_STRB; k++) begin
			write_check(addr_t'(wr_idx[3*k] * 4), $random(seed), strb_t'($random(seed)), 0);
			read_check(addr_t'(wr_idx[3*k] * 4), 0);
		end

		data = $random(seed);
		write_check(GPIO_START_ADDRESS + GPIO_LED_OFFSET, data, '1, 0);
		expect_data(data_t'(ref_led), data_t'(led_o), "led_o");
		read_check(GPIO_START_ADDRESS + GPIO_LED_OFFSET, 0);
		write_check(GPIO_START_ADDRESS + GPIO_LED_OFFSET, ~data, 4'hE, 0);  // LED byte not strobed
		read_check(GPIO_START_ADDRESS + GPIO_LED_OFFSET, 0);
		ref_sw = $random(seed);
		sw_i = ref_sw;
		repeat (10) @(posedge clk_i);
		#2;
		read_check(GPIO_START_ADDRESS + GPIO_SW_OFFSET, 0);
		write_check(GPIO_START_ADDRESS + GPIO_SW_OFFSET, ~data_t'(ref_sw), '1, 0);
		read_check(GPIO_START_ADDRESS + GPIO_SW_OFFSET, 0);
		read_check(GPIO_START_ADDRESS + 32'h8, 0);

		// Words 0 and 255 and the LED register are what the unmapped addresses alias
		write_check(MEM_START_ADDRESS, $random(seed), '1, 0);
		write_check(MEM_END_ADDRESS - 32'd3, $random(seed), '1, 0);
		for (int k = 0; k < NUM_BAD; k++) begin
			write_check(bad_addr[k], $random(seed), '1, 0);
			read_check(bad_addr[k], 0);
		end
		read_check(MEM_START_ADDRESS, 0);
		read_check(MEM_END_ADDRESS - 32'd3, 0);
		read_check(GPIO_START_ADDRESS + GPIO_LED_OFFSET, 0);
		expect_data(data_t'(ref_led), data_t'(led_o), "led_o");

		// One write and one read in flight together and both held off
		for (int k = 0; k < NUM_BP; k++) begin
			data = $random(seed);
			stall_w = rand_stall();
			stall_r = rand_stall();
			fork
				write_check(addr_t'(wr_idx[2*k] * 4), data, '1, stall_w);
				read_check(addr_t'(wr_idx[2*k + 1] * 4), stall_r);
			join
		end
		read_check(addr_t'(wr_idx[0] * 4), 0);

		reset_dut();
		repeat (2) @(posedge clk_i);
		$display("Data errors: %0d, response errors: %0d, other errors: %0d",
			data_errors, resp_errors, other_errors);
		if (data_errors + resp_errors + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// BRESP and RRESP encoding
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;  // No slave at this address

endpackage

`default_nettype wire

// File: logic/crossbar_axi.sv
`default_nettype none

module crossbar_axi (
	input  logic                clk_i,
	input  logic                rst_i,
	input  axi_lite_pkg::addr_t s_awaddr_i,
	input  logic                s_awvalid_i,
	output logic                s_awready_o,
	input  axi_lite_pkg::data_t s_wdata_i,
	input  axi_lite_pkg::strb_t s_wstrb_i,
	input  logic                s_wvalid_i,
	output logic                s_wready_o,
	output axi_lite_pkg::resp_t s_bresp_o,
	output logic                s_bvalid_o,
	input  logic                s_bready_i,
	input  axi_lite_pkg::addr_t s_araddr_i,
	input  logic                s_arvalid_i,
	output logic                s_arready_o,
	output axi_lite_pkg::data_t s_rdata_o,
	output axi_lite_pkg::resp_t s_rresp_o,
	output logic                s_rvalid_o,
	input  logic                s_rready_i,
	output axi_lite_pkg::addr_t mem_awaddr_o,
	output logic                mem_awvalid_o,
	input  logic                mem_awready_i,
	output axi_lite_pkg::data_t mem_wdata_o,
	output axi_lite_pkg::strb_t mem_wstrb_o,
	output logic                mem_wvalid_o,
	input  logic                mem_wready_i,
	input  axi_lite_pkg::resp_t mem_bresp_i,
	input  logic                mem_bvalid_i,
	output logic                mem_bready_o,
	output axi_lite_pkg::addr_t mem_araddr_o,
	output logic                mem_arvalid_o,
	input  logic                mem_arready_i,
	input  axi_lite_pkg::data_t mem_rdata_i,
	input  axi_lite_pkg::resp_t mem_rresp_i,
	input  logic                mem_rvalid_i,
	output logic                mem_rready_o,
	output axi_lite_pkg::addr_t gpio_awaddr_o,
	output logic                gpio_awvalid_o,
	input  logic                gpio_awready_i,
	output axi_lite_pkg::data_t gpio_wdata_o,
	output axi_lite_pkg::strb_t gpio_wstrb_o,
	output logic                gpio_wvalid_o,
	input  logic                gpio_wready_i,
	input  axi_lite_pkg::resp_t gpio_bresp_i,
	input  logic                gpio_bvalid_i,
	output logic                gpio_bready_o,
	output axi_lite_pkg::addr_t gpio_araddr_o,
	output logic                gpio_arvalid_o,
	input  logic                gpio_arready_i,
	input  axi_lite_pkg::data_t gpio_rdata_i,
	input  axi_lite_pkg::resp_t gpio_rresp_i,
	input  logic                gpio_rvalid_i,
	output logic                gpio_rready_o
);
	import axi_lite_pkg::*;
	import soc_map_pkg::*;

	endpoint_t aw_sel;
	endpoint_t ar_sel;
	endpoint_t wr_owner;
	endpoint_t rd_owner;
	logic wr_pending;
	logic rd_pending;
	logic wr_fire;
	logic rd_fire;

	function automatic endpoint_t decode(input addr_t addr);
		if (addr >= MEM_START_ADDRESS && addr <= MEM_END_ADDRESS)
			return EP_MEM;
		if (addr >= GPIO_START_ADDRESS && addr <= GPIO_END_ADDRESS)
			return EP_GPIO;
		return EP_NONE;
	endfunction

	assign aw_sel = decode(s_awaddr_i);
	assign ar_sel = decode(s_araddr_i);

	// Request steering, held off while that direction owes a response
	assign mem_awvalid_o = s_awvalid_i && !wr_pending && aw_sel == EP_MEM;
	assign mem_wvalid_o = s_wvalid_i && !wr_pending && aw_sel == EP_MEM;
	assign gpio_awvalid_o = s_awvalid_i && !wr_pending && aw_sel == EP_GPIO;
	assign gpio_wvalid_o = s_wvalid_i && !wr_pending && aw_sel == EP_GPIO;
	assign mem_arvalid_o = s_arvalid_i && !rd_pending && ar_sel == EP_MEM;
	assign gpio_arvalid_o = s_arvalid_i && !rd_pending && ar_sel == EP_GPIO;

	assign mem_awaddr_o = (aw_sel == EP_MEM) ? s_awaddr_i : '0;
	assign mem_wdata_o = (aw_sel == EP_MEM) ? s_wdata_i : '0;
	assign mem_wstrb_o = (aw_sel == EP_MEM) ? s_wstrb_i : '0;
	assign mem_araddr_o = (ar_sel == EP_MEM) ? s_araddr_i : '0;
	assign gpio_awaddr_o = (aw_sel == EP_GPIO) ? s_awaddr_i : '0;
	assign gpio_wdata_o = (aw_sel == EP_GPIO) ? s_wdata_i : '0;
	assign gpio_wstrb_o = (aw_sel == EP_GPIO) ? s_wstrb_i : '0;
	assign gpio_araddr_o = (ar_sel == EP_GPIO) ? s_araddr_i : '0;

	// Unmapped requests are accepted here
	assign s_awready_o = !wr_pending && ((aw_sel == EP_MEM) ? mem_awready_i :
		(aw_sel == EP_GPIO) ? gpio_awready_i : s_awvalid_i && s_wvalid_i);
	assign s_wready_o = !wr_pending && ((aw_sel == EP_MEM) ? mem_wready_i :
		(aw_sel == EP_GPIO) ? gpio_wready_i : s_awvalid_i && s_wvalid_i);
	assign s_arready_o = !rd_pending && ((ar_sel == EP_MEM) ? mem_arready_i :
		(ar_sel == EP_GPIO) ? gpio_arready_i : 1'b1);

	assign wr_fire = s_awvalid_i && s_awready_o && s_wvalid_i && s_wready_o;
	assign rd_fire = s_arvalid_i && s_arready_o;

	// Response merge from the owner, decode error answered from the pending flag
	assign s_bvalid_o = (wr_owner == EP_MEM) ? mem_bvalid_i :
		(wr_owner == EP_GPIO) ? gpio_bvalid_i : wr_pending;
	assign s_bresp_o = (wr_owner == EP_MEM) ? mem_bresp_i :
		(wr_owner == EP_GPIO) ? gpio_bresp_i : RESP_DECERR;
	assign mem_bready_o = s_bready_i && wr_pending && wr_owner == EP_MEM;
	assign gpio_bready_o = s_bready_i && wr_pending && wr_owner == EP_GPIO;

	assign s_rvalid_o = (rd_owner == EP_MEM) ? mem_rvalid_i :
		(rd_owner == EP_GPIO) ? gpio_rvalid_i : rd_pending;
	assign s_rdata_o = (rd_owner == EP_MEM) ? mem_rdata_i :
		(rd_owner == EP_GPIO) ? gpio_rdata_i : '0;
	assign s_rresp_o = (rd_owner == EP_MEM) ? mem_rresp_i :
		(rd_owner == EP_GPIO) ? gpio_rresp_i : RESP_DECERR;
	assign mem_rready_o = s_rready_i && rd_pending && rd_owner == EP_MEM;
	assign gpio_rready_o = s_rready_i && rd_pending && rd_owner == EP_GPIO;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_pending <= 1'b0;
			wr_owner <= EP_NONE;
		end else if (wr_fire) begin
			wr_pending <= 1'b1;
			wr_owner <= aw_sel;
		end else if (s_bvalid_o && s_bready_i) begin
			wr_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_pending <= 1'b0;
			rd_owner <= EP_NONE;
		end else if (rd_fire) begin
			rd_pending <= 1'b1;
			rd_owner <= ar_sel;
		end else if (s_rvalid_o && s_rready_i) begin
			rd_pending <= 1'b0;
		end
	end

	one_wr_target_a: assert property (@(posedge clk_i) disable iff (rst_i)
		!((mem_awvalid_o || mem_wvalid_o) && (gpio_awvalid_o || gpio_wvalid_o)));
	one_rd_target_a: assert property (@(posedge clk_i) disable iff (rst_i)
		!(mem_arvalid_o && gpio_arvalid_o));

	// Owner must survive until its response is taken
	wr_owner_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
		wr_pending && !(s_bvalid_o && s_bready_i) |=> wr_pending && $stable(wr_owner));
	rd_owner_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
		rd_pending && !(s_rvalid_o && s_rready_i) |=> rd_pending && $stable(rd_owner));

endmodule

`default_nettype wire

// File: logic/gpio_axi.sv
`default_nettype none

module gpio_axi (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  axi_lite_pkg::addr_t                 awaddr_i,
	input  logic                                awvalid_i,
	output logic                                awready_o,
	input  axi_lite_pkg::data_t                 wdata_i,
	input  axi_lite_pkg::strb_t                 wstrb_i,
	input  logic                                wvalid_i,
	output logic                                wready_o,
	output axi_lite_pkg::resp_t                 bresp_o,
	output logic                                bvalid_o,
	input  logic                                bready_i,
	input  axi_lite_pkg::addr_t                 araddr_i,
	input  logic                                arvalid_i,
	output logic                                arready_o,
	output axi_lite_pkg::data_t                 rdata_o,
	output axi_lite_pkg::resp_t                 rresp_o,
	output logic                                rvalid_o,
	input  logic                                rready_i,
	input  logic [soc_map_pkg::SW_WIDTH-1:0]    sw_i,
	output logic [soc_map_pkg::LED_WIDTH-1:0]   led_o
);
	import axi_lite_pkg::*;
	import soc_map_pkg::*;

	logic [SW_WIDTH-1:0] sw_meta;
	logic [SW_WIDTH-1:0] sw_sync;
	data_t rd_word;
	logic wr_fire;
	logic rd_fire;

	assign awready_o = awvalid_i && wvalid_i && !bvalid_o;
	assign wready_o = awready_o;
	assign wr_fire = awready_o;

	assign arready_o = !rvalid_o;
	assign rd_fire = arvalid_i && arready_o;

	assign bresp_o = RESP_OKAY;
	assign rresp_o = RESP_OKAY;

	// Two-flop synchronizer for the switch pins
	always_ff @(posedge clk_i) begin
		sw_meta <= sw_i;
		sw_sync <= sw_meta;
	end

	always_comb begin
		case (araddr_i[3:0])
			GPIO_SW_OFFSET: rd_word = data_t'(sw_sync);
			GPIO_LED_OFFSET: rd_word = data_t'(led_o);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rd_fire)
			rdata_o <= rd_word;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			led_o <= '0;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			// Switch register ignores writes
			if (wr_fire && awaddr_i[3:0] == GPIO_LED_OFFSET && wstrb_i[0])
				led_o <= wdata_i[LED_WIDTH-1:0];

			if (wr_fire)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;

			if (rd_fire)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	rvalid_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

`default_nettype wire

// File: logic/mem_axi.sv
`default_nettype none

module mem_axi (
	input  logic                clk_i,
	input  logic                rst_i,
	input  axi_lite_pkg::addr_t awaddr_i,
	input  logic                awvalid_i,
	output logic                awready_o,
	input  axi_lite_pkg::data_t wdata_i,
	input  axi_lite_pkg::strb_t wstrb_i,
	input  logic                wvalid_i,
	output logic                wready_o,
	output axi_lite_pkg::resp_t bresp_o,
	output logic                bvalid_o,
	input  logic                bready_i,
	input  axi_lite_pkg::addr_t araddr_i,
	input  logic                arvalid_i,
	output logic                arready_o,
	output axi_lite_pkg::data_t rdata_o,
	output axi_lite_pkg::resp_t rresp_o,
	output logic                rvalid_o,
	input  logic                rready_i
);
	import axi_lite_pkg::*;
	import soc_map_pkg::*;

	data_t mem [MEM_WORDS];
	logic [MEM_INDEX_WIDTH-1:0] wr_index;
	logic [MEM_INDEX_WIDTH-1:0] rd_index;
	logic wr_fire;
	logic rd_fire;

	// Word index without the byte bits
	assign wr_index = awaddr_i[MEM_INDEX_WIDTH+1:2];
	assign rd_index = araddr_i[MEM_INDEX_WIDTH+1:2];

	// AW and W are taken together and never while B is waiting
	assign awready_o = awvalid_i && wvalid_i && !bvalid_o;
	assign wready_o = awready_o;
	assign wr_fire = awready_o;

	assign arready_o = !rvalid_o;
	assign rd_fire = arvalid_i && arready_o;

	assign bresp_o = RESP_OKAY;
	assign rresp_o = RESP_OKAY;

	always_ff @(posedge clk_i) begin
		if (wr_fire) begin
			for (int i = 0; i < STRB_WIDTH; i++) begin
				if (wstrb_i[i])
					mem[wr_index][8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
	end

	// Same-cycle read of a word being written returns the old word
	always_ff @(posedge clk_i) begin
		if (rd_fire)
			rdata_o <= mem[rd_index];
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;

			if (rd_fire)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	bvalid_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
		bvalid_o && !bready_i |=> bvalid_o);

endmodule

`default_nettype wire

// File: logic/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// Block RAM window, 1 KiB
	localparam axi_lite_pkg::addr_t MEM_START_ADDRESS = 32'h0000_0000;
	localparam axi_lite_pkg::addr_t MEM_END_ADDRESS = 32'h0000_03FF;
	localparam int MEM_WORDS = 256;
	localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);

	// GPIO window, four word registers
	localparam axi_lite_pkg::addr_t GPIO_START_ADDRESS = 32'h1000_0000;
	localparam axi_lite_pkg::addr_t GPIO_END_ADDRESS = 32'h1000_000F;
	localparam logic [3:0] GPIO_SW_OFFSET = 4'h0;   // Read only
	localparam logic [3:0] GPIO_LED_OFFSET = 4'h4;

	localparam int SW_WIDTH = 4;
	localparam int LED_WIDTH = 8;  // Green LEDs low nibble, red LEDs high nibble

	typedef enum logic [1:0] {
		EP_MEM,
		EP_GPIO,
		EP_NONE
	} endpoint_t;

endpackage

`default_nettype wire

// File: logic/soc_top.sv
`default_nettype none

module soc_top (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  axi_lite_pkg::addr_t                 s_awaddr_i,
	input  logic                                s_awvalid_i,
	output logic                                s_awready_o,
	input  axi_lite_pkg::data_t                 s_wdata_i,
	input  axi_lite_pkg::strb_t                 s_wstrb_i,
	input  logic                                s_wvalid_i,
	output logic                                s_wready_o,
	output axi_lite_pkg::resp_t                 s_bresp_o,
	output logic                                s_bvalid_o,
	input  logic                                s_bready_i,
	input  axi_lite_pkg::addr_t                 s_araddr_i,
	input  logic                                s_arvalid_i,
	output logic                                s_arready_o,
	output axi_lite_pkg::data_t                 s_rdata_o,
	output axi_lite_pkg::resp_t                 s_rresp_o,
	output logic                                s_rvalid_o,
	input  logic                                s_rready_i,
	input  logic [soc_map_pkg::SW_WIDTH-1:0]    sw_i,
	output logic [soc_map_pkg::LED_WIDTH-1:0]   led_o
);
	import axi_lite_pkg::*;

	// Crossbar to block RAM
	addr_t mem_awaddr, mem_araddr;
	data_t mem_wdata, mem_rdata;
	strb_t mem_wstrb;
	resp_t mem_bresp, mem_rresp;
	logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
	logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;

	// Crossbar to GPIO
	addr_t gpio_awaddr, gpio_araddr;
	data_t gpio_wdata, gpio_rdata;
	strb_t gpio_wstrb;
	resp_t gpio_bresp, gpio_rresp;
	logic gpio_awvalid, gpio_awready, gpio_wvalid, gpio_wready, gpio_bvalid, gpio_bready;
	logic gpio_arvalid, gpio_arready, gpio_rvalid, gpio_rready;

	crossbar_axi crossbar_i (
		.*,  // Master side shares the top-level port names
		.mem_awaddr_o(mem_awaddr),
		.mem_awvalid_o(mem_awvalid),
		.mem_awready_i(mem_awready),
		.mem_wdata_o(mem_wdata),
		.mem_wstrb_o(mem_wstrb),
		.mem_wvalid_o(mem_wvalid),
		.mem_wready_i(mem_wready),
		.mem_bresp_i(mem_bresp),
		.mem_bvalid_i(mem_bvalid),
		.mem_bready_o(mem_bready),
		.mem_araddr_o(mem_araddr),
		.mem_arvalid_o(mem_arvalid),
		.mem_arready_i(mem_arready),
		.mem_rdata_i(mem_rdata),
		.mem_rresp_i(mem_rresp),
		.mem_rvalid_i(mem_rvalid),
		.mem_rready_o(mem_rready),
		.gpio_awaddr_o(gpio_awaddr),
		.gpio_awvalid_o(gpio_awvalid),
		.gpio_awready_i(gpio_awready),
		.gpio_wdata_o(gpio_wdata),
		.gpio_wstrb_o(gpio_wstrb),
		.gpio_wvalid_o(gpio_wvalid),
		.gpio_wready_i(gpio_wready),
		.gpio_bresp_i(gpio_bresp),
		.gpio_bvalid_i(gpio_bvalid),
		.gpio_bready_o(gpio_bready),
		.gpio_araddr_o(gpio_araddr),
		.gpio_arvalid_o(gpio_arvalid),
		.gpio_arready_i(gpio_arready),
		.gpio_rdata_i(gpio_rdata),
		.gpio_rresp_i(gpio_rresp),
		.gpio_rvalid_i(gpio_rvalid),
		.gpio_rready_o(gpio_rready)
	);

	mem_axi mem_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.awaddr_i(mem_awaddr),
		.awvalid_i(mem_awvalid),
		.awready_o(mem_awready),
		.wdata_i(mem_wdata),
		.wstrb_i(mem_wstrb),
		.wvalid_i(mem_wvalid),
		.wready_o(mem_wready),
		.bresp_o(mem_bresp),
		.bvalid_o(mem_bvalid),
		.bready_i(mem_bready),
		.araddr_i(mem_araddr),
		.arvalid_i(mem_arvalid),
		.arready_o(mem_arready),
		.rdata_o(mem_rdata),
		.rresp_o(mem_rresp),
		.rvalid_o(mem_rvalid),
		.rready_i(mem_rready)
	);

	gpio_axi gpio_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.awaddr_i(gpio_awaddr),
		.awvalid_i(gpio_awvalid),
		.awready_o(gpio_awready),
		.wdata_i(gpio_wdata),
		.wstrb_i(gpio_wstrb),
		.wvalid_i(gpio_wvalid),
		.wready_o(gpio_wready),
		.bresp_o(gpio_bresp),
		.bvalid_o(gpio_bvalid),
		.bready_i(gpio_bready),
		.araddr_i(gpio_araddr),
		.arvalid_i(gpio_arvalid),
		.arready_o(gpio_arready),
		.rdata_o(gpio_rdata),
		.rresp_o(gpio_rresp),
		.rvalid_o(gpio_rvalid),
		.rready_i(gpio_rready),
		.sw_i(sw_i),
		.led_o(led_o)
	);

endmodule

`default_nettype wire

// File: sim.f
logic/axi_lite_pkg.sv
logic/soc_map_pkg.sv
logic/mem_axi.sv
logic/gpio_axi.sv
logic/crossbar_axi.sv
logic/soc_top.sv
dv/soc_tb.sv
